// ==== source/game_pkg.sv ====
// ========================================
// game package
// screen geometry, sprite sizes, colours
// and the pixel-stream and position types
// ========================================
package game_pkg;

    // visible area in pixels
    localparam int SCREEN_W = 800;
    localparam int SCREEN_H = 600;

    // coordinate width, covers the whole timing frame
    localparam int COORD_W = 12;

    // enemy sprite is a solid square
    localparam int ENEMY_SIZE = 16;

    // projectile is a thin vertical bar
    localparam int SHOT_W = 2;
    localparam int SHOT_H = 6;

    // top left corner of a sprite
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } pos_t;

    // pixel timing as delivered by the video generator
    typedef struct packed {
        logic [COORD_W-1:0] hcount;
        logic [COORD_W-1:0] vcount;
        logic               blank;
    } vga_t;

    // 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // sprite colours
    localparam rgb_t ENEMY_RGB = '{r: 4'hf, g: 4'h3, b: 4'h1};
    localparam rgb_t SHOT_RGB  = '{r: 4'hf, g: 4'hf, b: 4'h0};

endpackage

// ==== source/enemy_pkg.sv ====
// ========================================
// enemy package
// enemy count, flight path, fire schedule,
// controller states and fire requests
// ========================================
package enemy_pkg;

    // three enemies share one flight path
    localparam int N_ENEMY = 3;
    localparam int IDX_W   = $clog2(N_ENEMY);

    // looped path table
    localparam int PATH_LEN = 32;
    localparam int ADDR_W   = 5;

    // starting point of each enemy, spread around the loop
    localparam logic [N_ENEMY-1:0][ADDR_W-1:0] ENEMY_PHASE = {5'd22, 5'd11, 5'd0};

    // one fire request per this many steps
    localparam int FIRE_EVERY = 8;
    localparam int STEP_W     = $clog2(FIRE_EVERY);

    // projectile fall per frame, in pixels
    localparam int SHOT_SPEED = 8;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_MOVE = 2'd1,
        ST_FIRE = 2'd2
    } en_state_t;

    // fire request, idx names the shooting enemy
    typedef struct packed {
        logic             req;
        logic [IDX_W-1:0] idx;
    } fire_req_t;

endpackage

// ==== source/enemy_ctl.sv ====
// ========================================
// enemy controller
// steps the path address of every enemy once
// per enabled frame and schedules the shots
// ========================================
`timescale 1ns/1ps

module enemy_ctl (
    input  logic                                           pclk,
    input  logic                                           rst_n,
    input  logic                                           frame,
    input  logic                                           enable,
    output logic [enemy_pkg::N_ENEMY-1:0][enemy_pkg::ADDR_W-1:0] addr,
    output enemy_pkg::fire_req_t                           fire,
    output enemy_pkg::en_state_t                           state
);
    import enemy_pkg::*;

    en_state_t         state_nxt;
    logic              step;
    logic              step_wrap;
    logic [STEP_W-1:0] step_cnt;
    logic [IDX_W-1:0]  shooter;

    // one path step per enabled frame
    assign step = frame && enable;

    // last step of a fire period
    assign step_wrap = step && (step_cnt == STEP_W'(FIRE_EVERY - 1));

    // state register
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                // wait for the first enabled frame
                if (step) begin
                    state_nxt = step_wrap ? ST_FIRE : ST_MOVE;
                end
            end
            ST_MOVE: begin
                if (step_wrap) begin
                    state_nxt = ST_FIRE;
                end
            end
            ST_FIRE: begin
                // single cycle unless another firing step lands here
                state_nxt = step_wrap ? ST_FIRE : ST_MOVE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // path addresses and step count, both frozen while disabled
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            addr     <= ENEMY_PHASE;
            step_cnt <= '0;
        end else if (step) begin
            for (int i = 0; i < N_ENEMY; i++) begin
                // loop back to the first path point
                addr[i] <= (addr[i] == ADDR_W'(PATH_LEN - 1)) ? '0 : addr[i] + 1'b1;
            end
            step_cnt <= step_wrap ? '0 : step_cnt + 1'b1;
        end
    end

    // fire request goes out one cycle after ST_FIRE,
    // together with the positions read for the new addresses
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            fire    <= '0;
            shooter <= '0;
        end else begin
            fire.req <= (state == ST_FIRE);
            fire.idx <= shooter;
            // shooter rotates 0, 1, 2
            if (state == ST_FIRE) begin
                shooter <= (shooter == IDX_W'(N_ENEMY - 1)) ? '0 : shooter + 1'b1;
            end
        end
    end

endmodule

// ==== source/path_rom.sv ====
// ========================================
// path ROM
// synchronous lookup of one flight-path
// point per cycle
// ========================================
`timescale 1ns/1ps

module path_rom #(
    parameter int PHASE = 0
) (
    input  logic                         pclk,
    input  logic [enemy_pkg::ADDR_W-1:0] addr,
    output game_pkg::pos_t               pos
);
    import enemy_pkg::*;

    // one 24-bit word per point, x in the upper half
    game_pkg::pos_t rom [PATH_LEN];

    // starting point must lie inside the table
    if (PHASE < 0 || PHASE >= PATH_LEN) begin : g_phase_check
        $error("path_rom phase %0d is outside the path table", PHASE);
    end

    // table contents fixed at elaboration
    initial begin
        $readmemb("enemy_path.mem", rom);
    end

    // registered read, point appears one cycle after its address
    always_ff @(posedge pclk) begin
        pos <= rom[addr];
    end

endmodule

// ==== source/shot_unit.sv ====
// ========================================
// enemy projectile
// launches from the shooting enemy, falls
// each frame, retires at the screen bottom
// ========================================
`timescale 1ns/1ps

module shot_unit (
    input  logic                                      pclk,
    input  logic                                      rst_n,
    input  logic                                      frame,
    input  enemy_pkg::fire_req_t                      fire,
    input  game_pkg::pos_t [enemy_pkg::N_ENEMY-1:0]   enemy_pos,
    output game_pkg::pos_t                            shot_pos,
    output logic                                      shot_active,
    output logic                                      shot_fired
);
    import game_pkg::*;
    import enemy_pkg::*;

    pos_t               muzzle;
    logic               launch;
    logic [COORD_W-1:0] fall_y;

    // only one projectile in flight, extra requests are dropped
    assign launch = fire.req && !shot_active;

    // muzzle is centred just below the shooter
    assign muzzle.x = enemy_pos[fire.idx].x + COORD_W'(ENEMY_SIZE / 2);
    assign muzzle.y = enemy_pos[fire.idx].y + COORD_W'(ENEMY_SIZE);

    // height after this frame's fall
    assign fall_y = shot_pos.y + COORD_W'(SHOT_SPEED);

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            shot_pos    <= '0;
            shot_active <= 1'b0;
            shot_fired  <= 1'b0;
        end else begin
            // one-cycle launch pulse
            shot_fired <= launch;
            if (launch) begin
                shot_pos    <= muzzle;
                shot_active <= 1'b1;
            end else if (frame && shot_active) begin
                shot_pos.y <= fall_y;
                // gone once it reaches the bottom edge
                if (fall_y >= COORD_W'(SCREEN_H)) begin
                    shot_active <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== source/sprite_overlay.sv ====
// ========================================
// sprite overlay
// paints enemy and projectile boxes over
// the incoming pixel stream, 1 cycle delay
// ========================================
`timescale 1ns/1ps

module sprite_overlay (
    input  logic                                    pclk,
    input  logic                                    rst_n,
    input  game_pkg::vga_t                          vga_in,
    input  game_pkg::rgb_t                          rgb_in,
    input  game_pkg::pos_t [enemy_pkg::N_ENEMY-1:0] enemy_pos,
    input  game_pkg::pos_t                          shot_pos,
    input  logic                                    shot_active,
    output game_pkg::vga_t                          vga_out,
    output game_pkg::rgb_t                          rgb_out
);
    import game_pkg::*;
    import enemy_pkg::*;

    logic visible;
    logic enemy_hit;
    logic shot_hit;
    rgb_t rgb_nxt;

    // pixel inside a w by h box anchored at p
    function automatic logic in_box(input vga_t v, input pos_t p, input int w, input int h);
        logic hit_x;
        logic hit_y;
        hit_x = (v.hcount >= p.x) && (v.hcount < p.x + w);
        hit_y = (v.vcount >= p.y) && (v.vcount < p.y + h);
        return hit_x && hit_y;
    endfunction

    // blanking and anything off screen stay black
    assign visible = !vga_in.blank
                     && (vga_in.hcount < COORD_W'(SCREEN_W))
                     && (vga_in.vcount < COORD_W'(SCREEN_H));

    // projectile drawn only while in flight
    assign shot_hit = shot_active && in_box(vga_in, shot_pos, SHOT_W, SHOT_H);

    // any enemy box
    always_comb begin
        enemy_hit = 1'b0;
        for (int i = 0; i < N_ENEMY; i++) begin
            if (in_box(vga_in, enemy_pos[i], ENEMY_SIZE, ENEMY_SIZE)) begin
                enemy_hit = 1'b1;
            end
        end
    end

    // black, projectile, enemy, background
    always_comb begin
        if (!visible) begin
            rgb_nxt = '0;
        end else if (shot_hit) begin
            rgb_nxt = SHOT_RGB;
        end else if (enemy_hit) begin
            rgb_nxt = ENEMY_RGB;
        end else begin
            rgb_nxt = rgb_in;
        end
    end

    // timing delayed to match the colour
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            vga_out <= '0;
            rgb_out <= '0;
        end else begin
            vga_out <= vga_in;
            rgb_out <= rgb_nxt;
        end
    end

endmodule

// ==== source/enemy_top.sv ====
// ========================================
// enemy subsystem top
// controller, path ROMs, projectile and
// sprite overlay
// ========================================
`timescale 1ns/1ps

module enemy_top (
    input  logic                                    pclk,
    input  logic                                    rst_n,
    input  logic                                    frame,
    input  logic                                    enable,
    input  game_pkg::vga_t                          vga_in,
    input  game_pkg::rgb_t                          rgb_in,
    output game_pkg::vga_t                          vga_out,
    output game_pkg::rgb_t                          rgb_out,
    output game_pkg::pos_t [enemy_pkg::N_ENEMY-1:0] enemy_pos,
    output game_pkg::pos_t                          shot_pos,
    output logic                                    shot_active,
    output logic                                    shot_fired
);
    import enemy_pkg::*;

    // one path address per enemy
    logic [N_ENEMY-1:0][ADDR_W-1:0] path_addr;
    fire_req_t                      fire_req;

    // state is only observed inside the controller
    enemy_ctl u_ctl (
        .pclk   (pclk),
        .rst_n  (rst_n),
        .frame  (frame),
        .enable (enable),
        .addr   (path_addr),
        .fire   (fire_req),
        .state  ()
    );

    // one ROM per enemy, same table
    for (genvar i = 0; i < N_ENEMY; i++) begin : g_path
        path_rom #(
            .PHASE (ENEMY_PHASE[i])
        ) u_path_rom (
            .pclk (pclk),
            .addr (path_addr[i]),
            .pos  (enemy_pos[i])
        );
    end

    shot_unit u_shot (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .frame       (frame),
        .fire        (fire_req),
        .enemy_pos   (enemy_pos),
        .shot_pos    (shot_pos),
        .shot_active (shot_active),
        .shot_fired  (shot_fired)
    );

    sprite_overlay u_overlay (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .vga_in      (vga_in),
        .rgb_in      (rgb_in),
        .enemy_pos   (enemy_pos),
        .shot_pos    (shot_pos),
        .shot_active (shot_active),
        .vga_out     (vga_out),
        .rgb_out     (rgb_out)
    );

endmodule

// ==== tests/enemy_assert.sv ====
// ========================================
// enemy assertions
// fire timing and projectile pulse rules
// ========================================
`timescale 1ns/1ps

module enemy_assert (
    input logic                 pclk,
    input logic                 rst_n,
    input logic                 frame,
    input enemy_pkg::en_state_t state,
    input enemy_pkg::fire_req_t fire,
    input logic                 shot_active,
    input logic                 shot_fired
);
    import enemy_pkg::*;

    // failure count, read back by the testbench
    int fails = 0;

    // request only in the cycle right after ST_FIRE
    fire_after_state: assert property (
        @(posedge pclk) disable iff (!rst_n)
        fire.req |-> $past(state) == ST_FIRE
    ) else begin
        fails++;
        $error("fire request raised outside the cycle after ST_FIRE");
    end

    // launch pulse lasts one cycle
    fired_one_cycle: assert property (
        @(posedge pclk) disable iff (!rst_n)
        shot_fired |=> !shot_fired
    ) else begin
        fails++;
        $error("shot_fired held high for more than one cycle");
    end

    // projectile retires only on a frame
    retire_on_frame: assert property (
        @(posedge pclk) disable iff (!rst_n)
        $fell(shot_active) |-> $past(frame)
    ) else begin
        fails++;
        $error("shot_active dropped without a frame strobe");
    end

endmodule

// controller state is internal, picked up through the hierarchy
bind enemy_top enemy_assert u_assert (
    .pclk        (pclk),
    .rst_n       (rst_n),
    .frame       (frame),
    .state       (u_ctl.state),
    .fire        (fire_req),
    .shot_active (shot_active),
    .shot_fired  (shot_fired)
);

// ==== tests/enemy_monitor.sv ====
// ========================================
// enemy monitor
// models paths, fire schedule, projectile
// and overlay and compares the DUT outputs
// ========================================
`timescale 1ns/1ps

module enemy_monitor (
    input  logic                                    pclk,
    input  logic                                    rst_n,
    input  logic                                    frame,
    input  logic                                    enable,
    input  game_pkg::vga_t                          vga_in,
    input  game_pkg::rgb_t                          rgb_in,
    input  game_pkg::vga_t                          vga_out,
    input  game_pkg::rgb_t                          rgb_out,
    input  game_pkg::pos_t [enemy_pkg::N_ENEMY-1:0] enemy_pos,
    input  game_pkg::pos_t                          shot_pos,
    input  logic                                    shot_active,
    input  logic                                    shot_fired,
    output int                                      checks,
    output int                                      errors
);
    import game_pkg::*;
    import enemy_pkg::*;

    pos_t path [PATH_LEN];
    int   m_addr [N_ENEMY];
    pos_t m_pos [N_ENEMY];
    int   m_steps;
    int   m_shooter;
    int   m_req_idx;
    logic fire_due;
    logic m_req;
    pos_t m_shot;
    logic m_active;
    logic m_fired;
    vga_t m_vga;
    rgb_t m_rgb;
    // rising edges seen so far, saturating
    logic [1:0] warm = '0;

    initial begin
        checks = 0;
        errors = 0;
        $readmemb("enemy_path.mem", path);
    end

    // pixel inside a w by h box at p
    function automatic logic covers(input vga_t v, input pos_t p, input int w, input int h);
        logic in_x;
        logic in_y;
        in_x = (int'(v.hcount) >= int'(p.x)) && (int'(v.hcount) < int'(p.x) + w);
        in_y = (int'(v.vcount) >= int'(p.y)) && (int'(v.vcount) < int'(p.y) + h);
        return in_x && in_y;
    endfunction

    // blank, then projectile, then enemy, then background
    function automatic rgb_t pixel_colour(input vga_t v, input rgb_t bg);
        logic in_enemy;
        in_enemy = 1'b0;
        for (int i = 0; i < N_ENEMY; i++) begin
            if (covers(v, m_pos[i], ENEMY_SIZE, ENEMY_SIZE)) begin
                in_enemy = 1'b1;
            end
        end
        if (v.blank) begin
            return '0;
        end else if (m_active && covers(v, m_shot, SHOT_W, SHOT_H)) begin
            return SHOT_RGB;
        end else if (in_enemy) begin
            return ENEMY_RGB;
        end
        return bg;
    endfunction

    always @(posedge pclk or negedge rst_n) begin : model
        logic launch;
        if (!rst_n) begin
            for (int i = 0; i < N_ENEMY; i++) begin
                m_addr[i] <= ENEMY_PHASE[i];
                m_pos[i]  <= path[ENEMY_PHASE[i]];
            end
            m_steps   <= 0;
            m_shooter <= 0;
            m_req_idx <= 0;
            fire_due  <= 1'b0;
            m_req     <= 1'b0;
            m_shot    <= '0;
            m_active  <= 1'b0;
            m_fired   <= 1'b0;
            m_vga     <= '0;
            m_rgb     <= '0;
        end else begin
            launch = m_req && !m_active;
            // one step per enabled frame
            if (frame && enable) begin
                for (int i = 0; i < N_ENEMY; i++) begin
                    m_addr[i] <= (m_addr[i] + 1) % PATH_LEN;
                end
                m_steps <= (m_steps + 1) % FIRE_EVERY;
            end
            // every 8th step raises a request two cycles later
            fire_due <= frame && enable && (m_steps == FIRE_EVERY - 1);
            m_req    <= fire_due;
            if (fire_due) begin
                m_req_idx <= m_shooter;
                m_shooter <= (m_shooter + 1) % N_ENEMY;
            end
            // ROM read lags its address by a cycle
            for (int i = 0; i < N_ENEMY; i++) begin
                m_pos[i] <= path[m_addr[i]];
            end
            // launch from the muzzle of the requesting enemy
            m_fired <= launch;
            if (launch) begin
                m_shot.x <= m_pos[m_req_idx].x + ENEMY_SIZE / 2;
                m_shot.y <= m_pos[m_req_idx].y + ENEMY_SIZE;
                m_active <= 1'b1;
            end else if (frame && m_active) begin
                m_shot.y <= m_shot.y + SHOT_SPEED;
                if (m_shot.y + SHOT_SPEED >= SCREEN_H) begin
                    m_active <= 1'b0;
                end
            end
            // overlay colour one cycle behind its pixel
            m_vga <= vga_in;
            m_rgb <= pixel_colour(vga_in, rgb_in);
        end
    end

    // ROM output is valid from the second edge on
    always @(posedge pclk) begin
        warm <= {warm[0], 1'b1};
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // outputs are settled mid-cycle
    always @(negedge pclk) begin
        if (warm[1]) begin
            for (int i = 0; i < N_ENEMY; i++) begin
                compare($sformatf("enemy_pos[%0d]", i), m_pos[i], enemy_pos[i]);
            end
            compare("shot_active", m_active, shot_active);
            compare("shot_fired", m_fired, shot_fired);
            // position only matters in flight
            if (m_active) begin
                compare("shot_pos", m_shot, shot_pos);
            end
            compare("vga_out", m_vga, vga_out);
            compare("rgb_out", m_rgb, rgb_out);
        end
    end

endmodule

// ==== tests/enemy_tb.sv ====
// ========================================
// enemy subsystem testbench
// runs the stimulus table against the DUT
// and reports the verdict
// ========================================
`timescale 1ns/1ps

module enemy_tb;
    import game_pkg::*;
    import enemy_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int FRAME_GAP  = 8;
    localparam int N_ENTRY    = 8;
    localparam int MARGIN     = 64;

    // frames to issue, enable level, probe pixel with blank and background
    typedef struct packed {
        logic [7:0]         frames;
        logic               en;
        logic [COORD_W-1:0] hcount;
        logic [COORD_W-1:0] vcount;
        logic               blank;
        rgb_t               bg;
    } entry_t;

    localparam entry_t STIM [N_ENTRY] = '{
        '{8'd3,  1'b1, 12'd700, 12'd500, 1'b0, 12'h123},  // background
        '{8'd2,  1'b0, 12'd325, 12'd70,  1'b0, 12'h0a5},  // enemy 0, frozen
        '{8'd6,  1'b1, 12'd648, 12'd100, 1'b1, 12'hfff},  // blanking, first shot
        '{8'd3,  1'b0, 12'd648, 12'd90,  1'b0, 12'h246},  // shot over enemy 0
        '{8'd64, 1'b1, 12'd760, 12'd560, 1'b0, 12'h321},  // expiry, wrap, drops
        '{8'd2,  1'b0, 12'd130, 12'd85,  1'b0, 12'h0f0},  // enemy 2, frozen
        '{8'd70, 1'b1, 12'd20,  12'd20,  1'b0, 12'h456},  // shooter 1 launch
        '{8'd4,  1'b0, 12'd457, 12'd274, 1'b0, 12'h789}   // falling shot
    };

    logic                     pclk = 1'b0;
    logic                     rst_n;
    logic                     frame;
    logic                     enable;
    vga_t                     vga_in;
    vga_t                     vga_out;
    rgb_t                     rgb_in;
    rgb_t                     rgb_out;
    pos_t [N_ENEMY-1:0]       enemy_pos;
    pos_t                     shot_pos;
    logic                     shot_active;
    logic                     shot_fired;
    int                       checks;
    int                       errors;

    always #(CLK_PERIOD / 2) pclk = ~pclk;

    enemy_top uut (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .frame       (frame),
        .enable      (enable),
        .vga_in      (vga_in),
        .rgb_in      (rgb_in),
        .vga_out     (vga_out),
        .rgb_out     (rgb_out),
        .enemy_pos   (enemy_pos),
        .shot_pos    (shot_pos),
        .shot_active (shot_active),
        .shot_fired  (shot_fired)
    );

    enemy_monitor u_mon (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .frame       (frame),
        .enable      (enable),
        .vga_in      (vga_in),
        .rgb_in      (rgb_in),
        .vga_out     (vga_out),
        .rgb_out     (rgb_out),
        .enemy_pos   (enemy_pos),
        .shot_pos    (shot_pos),
        .shot_active (shot_active),
        .shot_fired  (shot_fired),
        .checks      (checks),
        .errors      (errors)
    );

    function automatic int total_frames();
        int sum;
        sum = 0;
        for (int i = 0; i < N_ENTRY; i++) begin
            sum += STIM[i].frames;
        end
        return sum;
    endfunction

    // hold the probe pixel, one frame strobe at the end of every 8 cycles
    task automatic run_entry(input entry_t s);
        @(posedge pclk);
        #5;
        enable        = s.en;
        vga_in.hcount = s.hcount;
        vga_in.vcount = s.vcount;
        vga_in.blank  = s.blank;
        rgb_in        = s.bg;
        for (int f = 0; f < s.frames; f++) begin
            repeat (FRAME_GAP - 1) @(posedge pclk);
            #5 frame = 1'b1;
            @(posedge pclk);
            #5 frame = 1'b0;
        end
    endtask

    // watchdog sized from the table length
    initial begin
        #((total_frames() * FRAME_GAP + N_ENTRY + MARGIN) * CLK_PERIOD);
        $display("timeout: the stimulus table did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n  = 1'b0;
        frame  = 1'b0;
        enable = 1'b0;
        vga_in = '0;
        rgb_in = '0;
        // reset over three rising edges
        repeat (3) @(posedge pclk);
        #5 rst_n = 1'b1;
        // quiet cycles, monitor sees the reset state
        repeat (4) @(posedge pclk);
        for (int i = 0; i < N_ENTRY; i++) begin
            run_entry(STIM[i]);
        end
        // let the last launch and overlay settle
        repeat (8) @(posedge pclk);
        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, uut.u_assert.fails);
        if (errors + uut.u_assert.fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== enemy_path.mem ====
// one flight-path point per line, binary
// x (12 bits) _ y (12 bits), point 0 first
000010000000_000001000000
000011000000_000001000000
000100000000_000001000000
000101000000_000001000000
000110000000_000001000000
000111000000_000001000000
001000000000_000001000000
001001000000_000001000000
001010000000_000001000000
001010000000_000001010000
001010000000_000001100000
001010000000_000001110000
001010000000_000010000000
001010000000_000010010000
001010000000_000010100000
001010000000_000010110000
001010000000_000011000000
001001000000_000011000000
001000000000_000011000000
000111000000_000011000000
000110000000_000011000000
000101000000_000011000000
000100000000_000011000000
000011000000_000011000000
000010000000_000011000000
000010000000_000010110000
000010000000_000010100000
000010000000_000010010000
000010000000_000010000000
000010000000_000001110000
000010000000_000001100000
000010000000_000001010000

// ==== tb.f ====
source/game_pkg.sv
source/enemy_pkg.sv
source/enemy_ctl.sv
source/path_rom.sv
source/shot_unit.sv
source/sprite_overlay.sv
source/enemy_top.sv
tests/enemy_assert.sv
tests/enemy_monitor.sv
tests/enemy_tb.sv
